// File: include/apb_checker_params.svh
// APB checker parameters
`ifndef APB_CHECKER_PARAMS_SVH
`define APB_CHECKER_PARAMS_SVH

////////////////////////////////
// APB bus
////////////////////////////////

// Address and data widths
`define APB_ADDR_W 32
`define APB_DATA_W 32
// One strobe per data byte
`define APB_STRB_W 4
// Low address bits that pick a byte lane
`define APB_LANE_W 2

// Access cycles allowed before the watchdog trips
`define WD_LIMIT 16

////////////////////////////////
// Log registers
////////////////////////////////

`define LOG_CNT_W 16
`define WB_ADR_W 4
// Word offsets on the Wishbone port
`define REG_STATUS 0
`define REG_COUNT 1
`define REG_MASK 2

`endif

// File: src/apb_checker_pkg.sv
// APB checker types
`include "apb_checker_params.svh"

package apb_checker_pkg;

  ////////////////////////////////
  // APB bus
  ////////////////////////////////

  // Request as seen on the bus
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   pwrite;
    logic [`APB_STRB_W-1:0] pstrb;
    logic [2:0]             pprot;
    logic [`APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  // Completer response, only pready is monitored
  typedef struct packed {
    logic                   pready;
    logic                   pslverr;
    logic [`APB_DATA_W-1:0] prdata;
  } apb_rsp_t;

  // One flag per rule, psel_drop is bit 0
  typedef struct packed {
    logic watchdog;
    logic addr_misaligned;
    logic pstrb_shape;
    logic pwdata_unstable;
    logic pprot_unstable;
    logic pstrb_unstable;
    logic pwrite_unstable;
    logic paddr_unstable;
    logic penable_access;
    logic penable_setup;
    logic psel_drop;
  } viol_t;

  // Transfer phase from the tracker
  typedef struct packed {
    logic setup;
    logic access;
    logic hold_window;
  } phase_t;

  ////////////////////////////////
  // Wishbone classic
  ////////////////////////////////

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`WB_ADR_W-1:0] adr;
    logic [31:0]          dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

// File: src/apb_phase_tracker.sv
// APB phase tracker
`timescale 1ns/1ps
`include "apb_checker_params.svh"

module apb_phase_tracker (
  input  logic                      PCLK,
  input  logic                      PRESETn,
  input  apb_checker_pkg::apb_req_t req,
  input  apb_checker_pkg::apb_rsp_t rsp,
  output apb_checker_pkg::phase_t   phase,
  output apb_checker_pkg::viol_t    viol
);

  // Counter wide enough to hold WD_LIMIT itself
  localparam int WD_W = $clog2(`WD_LIMIT + 1);

  logic            prev_psel;
  logic            prev_penable;
  logic            prev_pready;
  logic            access_q;
  logic            setup;
  logic            wd_clear;
  logic [WD_W-1:0] wd_cnt;

  ////////////////////////////////
  // Phases
  ////////////////////////////////

  // New transfer: psel rises, or follows a completed one
  assign setup = req.psel & (~prev_psel | (prev_penable & prev_pready));

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      prev_psel    <= 1'b0;
      prev_penable <= 1'b0;
      prev_pready  <= 1'b0;
      access_q     <= 1'b0;
    end
    else
    begin
      prev_psel    <= req.psel;
      prev_penable <= req.penable;
      prev_pready  <= rsp.pready;
      // Access starts after setup, ends on pready
      // An aborted transfer (psel gone) also ends it
      if (setup)
        access_q <= 1'b1;
      else if (rsp.pready || !req.psel)
        access_q <= 1'b0;
    end
  end

  assign phase.setup  = setup;
  assign phase.access = access_q;
  // Completer stalled last cycle, request must hold
  assign phase.hold_window = req.psel & prev_psel & ~prev_pready;

  ////////////////////////////////
  // Watchdog
  ////////////////////////////////

  // Idle bus or a completed transfer restarts the count
  assign wd_clear = ~req.psel | (req.penable & rsp.pready);

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      wd_cnt <= '0;
    else if (wd_clear)
      wd_cnt <= '0;
    else if (wd_cnt != WD_W'(`WD_LIMIT))
      wd_cnt <= wd_cnt + 1'b1;
  end

  ////////////////////////////////
  // Rule flags
  ////////////////////////////////

  always_comb
  begin
    viol = '0;
    // psel fell while the completer was still stalling
    viol.psel_drop      = ~req.psel & prev_psel & ~prev_pready;
    viol.penable_setup  = setup & req.penable;
    viol.penable_access = access_q & req.psel & ~req.penable;
    // Single pulse on the edge where the count hits the limit
    viol.watchdog = ~wd_clear & (wd_cnt == WD_W'(`WD_LIMIT - 1));
  end

endmodule

// File: src/apb_hold_checker.sv
// APB wait-state hold checker
`timescale 1ns/1ps

module apb_hold_checker (
  input  logic                      PCLK,
  input  logic                      PRESETn,
  input  apb_checker_pkg::apb_req_t req,
  input  apb_checker_pkg::phase_t   phase,
  output apb_checker_pkg::viol_t    viol
);

  // Request as sampled on the previous edge
  apb_checker_pkg::apb_req_t prev_req;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      prev_req <= '0;
    else
      prev_req <= req;
  end

  ////////////////////////////////
  // Field compares
  ////////////////////////////////

  // Only meaningful while the completer inserts wait states
  always_comb
  begin
    viol = '0;
    if (phase.hold_window)
    begin
      viol.paddr_unstable  = (req.paddr != prev_req.paddr);
      viol.pwrite_unstable = (req.pwrite != prev_req.pwrite);
      viol.pstrb_unstable  = (req.pstrb != prev_req.pstrb);
      viol.pprot_unstable  = (req.pprot != prev_req.pprot);
      // Write data is held for reads too
      viol.pwdata_unstable = (req.pwdata != prev_req.pwdata);
    end
  end

endmodule

// File: src/apb_strobe_checker.sv
// APB strobe and alignment checker
`timescale 1ns/1ps
`include "apb_checker_params.svh"

module apb_strobe_checker (
  input  apb_checker_pkg::apb_req_t req,
  input  apb_checker_pkg::phase_t   phase,
  output apb_checker_pkg::viol_t    viol
);

  ////////////////////////////////
  // Helpers
  ////////////////////////////////

  // One naturally aligned group of 1, 2, 4 ... bytes
  function automatic logic shape_valid(input logic [`APB_STRB_W-1:0] strb);
    logic [`APB_STRB_W-1:0] grp;
    logic                   ok;
    ok = 1'b0;
    for (int sz = 1; sz <= `APB_STRB_W; sz = sz * 2)
    begin
      for (int off = 0; off < `APB_STRB_W; off = off + sz)
      begin
        grp = ((`APB_STRB_W'(1) << sz) - 1) << off;
        ok  = ok | (strb == grp);
      end
    end
    return ok;
  endfunction

  // Lane of the lowest active strobe
  function automatic logic [`APB_LANE_W-1:0] low_lane(input logic [`APB_STRB_W-1:0] strb);
    logic [`APB_LANE_W-1:0] idx;
    idx = '0;
    // Scan downward so the lowest set bit wins
    for (int i = `APB_STRB_W - 1; i >= 0; i--)
    begin
      if (strb[i])
        idx = `APB_LANE_W'(i);
    end
    return idx;
  endfunction

  logic                   strb_any;
  logic                   strb_ok;
  logic [`APB_LANE_W-1:0] lane;

  assign strb_any = |req.pstrb;
  assign strb_ok  = shape_valid(req.pstrb);
  assign lane     = req.paddr[`APB_LANE_W-1:0];

  ////////////////////////////////
  // Rule flags
  ////////////////////////////////

  always_comb
  begin
    viol = '0;
    if (phase.setup)
    begin
      // Zero strobes on a write is legal, nothing to check
      viol.pstrb_shape = req.pwrite & strb_any & ~strb_ok;
      if (req.pwrite)
        viol.addr_misaligned = strb_any & strb_ok & (lane != low_lane(req.pstrb));
      else
        viol.addr_misaligned = (lane != '0);  // reads are full words
    end
  end

endmodule

// File: src/apb_violation_log.sv
// APB violation log
`timescale 1ns/1ps
`include "apb_checker_params.svh"

module apb_violation_log (
  input  logic                     PCLK,
  input  logic                     PRESETn,
  input  apb_checker_pkg::viol_t   viol,
  input  apb_checker_pkg::wb_req_t wb_req,
  output apb_checker_pkg::wb_rsp_t wb_rsp,
  output logic                     irq
);

  localparam int NFLAG = $bits(apb_checker_pkg::viol_t);

  logic [NFLAG-1:0]      status;
  logic [NFLAG-1:0]      mask;
  logic [`LOG_CNT_W-1:0] count;
  logic                  ack_q;
  logic [31:0]           rd_dat;
  logic                  wb_acc;
  logic                  wr_status;
  logic                  wr_count;
  logic                  wr_mask;
  logic                  any_viol;

  ////////////////////////////////
  // Wishbone decode
  ////////////////////////////////

  // New cycle only when not already acknowledging
  assign wb_acc    = wb_req.cyc & wb_req.stb & ~ack_q;
  assign wr_status = wb_acc & wb_req.we & (wb_req.adr == `WB_ADR_W'(`REG_STATUS));
  assign wr_count  = wb_acc & wb_req.we & (wb_req.adr == `WB_ADR_W'(`REG_COUNT));
  assign wr_mask   = wb_acc & wb_req.we & (wb_req.adr == `WB_ADR_W'(`REG_MASK));

  assign any_viol = |viol;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      ack_q <= 1'b0;
    else
      ack_q <= wb_acc;
  end

  // Read data captured on the same edge that raises ack
  always_ff @(posedge PCLK)
  begin
    if (wb_acc)
    begin
      case (wb_req.adr)
        `WB_ADR_W'(`REG_STATUS): rd_dat <= 32'(status);
        `WB_ADR_W'(`REG_COUNT):  rd_dat <= 32'(count);
        `WB_ADR_W'(`REG_MASK):   rd_dat <= 32'(mask);
        default:                 rd_dat <= '0;
      endcase
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rd_dat;

  ////////////////////////////////
  // Status, count and mask
  ////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      status <= '0;
      count  <= '0;
      mask   <= '0;
    end
    else
    begin
      // Write-one-to-clear, a flag firing now stays set
      if (wr_status)
        status <= (status & ~wb_req.dat[NFLAG-1:0]) | viol;
      else
        status <= status | viol;
      // Clear still counts an event in the same cycle
      if (wr_count)
        count <= `LOG_CNT_W'(any_viol);
      else if (any_viol && count != '1)
        count <= count + 1'b1;
      if (wr_mask)
        mask <= wb_req.dat[NFLAG-1:0];
    end
  end

  // Enabled flags only
  assign irq = |(status & mask);

endmodule

// File: src/apb_checker_top.sv
// APB bus monitor top
`timescale 1ns/1ps

module apb_checker_top (
  input  logic                      PCLK,
  input  logic                      PRESETn,
  input  apb_checker_pkg::apb_req_t req,
  input  apb_checker_pkg::apb_rsp_t rsp,
  input  apb_checker_pkg::wb_req_t  wb_req,
  output apb_checker_pkg::wb_rsp_t  wb_rsp,
  output logic                      irq
);

  apb_checker_pkg::phase_t phase;
  apb_checker_pkg::viol_t  viol_trk;
  apb_checker_pkg::viol_t  viol_hold;
  apb_checker_pkg::viol_t  viol_strb;
  apb_checker_pkg::viol_t  viol;

  ////////////////////////////////
  // Checkers
  ////////////////////////////////

  // Phase tracking feeds the other two
  apb_phase_tracker u_trk (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .req     (req),
    .rsp     (rsp),
    .phase   (phase),
    .viol    (viol_trk)
  );

  apb_hold_checker u_hold (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .req     (req),
    .phase   (phase),
    .viol    (viol_hold)
  );

  apb_strobe_checker u_strb (
    .req   (req),
    .phase (phase),
    .viol  (viol_strb)
  );

  // Each checker leaves its other fields at zero
  assign viol = viol_trk | viol_hold | viol_strb;

  // Sticky flags and processor access
  apb_violation_log u_log (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .viol    (viol),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .irq     (irq)
  );

endmodule

// File: sim/apb_checker_asserts.sv
// APB checker bound assertions
`timescale 1ns/1ps

module apb_checker_asserts #(
  // Selects the Wishbone and irq group or the phase group
  parameter bit CHECK_WB = 1'b1
) (
  input logic                     PCLK,
  input logic                     PRESETn,
  input apb_checker_pkg::wb_req_t wb_req,
  input apb_checker_pkg::wb_rsp_t wb_rsp,
  input logic                     irq,
  input apb_checker_pkg::phase_t  phase
);

  if (CHECK_WB)
  begin : g_wb

    //////////////////////////////
    // Wishbone
    //////////////////////////////

    // Ack is a single-cycle pulse
    assert property (@(posedge PCLK) disable iff (!PRESETn) wb_rsp.ack |=> !wb_rsp.ack)
      else $error("Wishbone ack held for more than one cycle");

    // Ack only answers a cycle with cyc and stb
    assert property (@(posedge PCLK) disable iff (!PRESETn)
      wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
      else $error("Wishbone ack without a request");

    // Interrupt quiet in and just out of reset
    assert property (@(posedge PCLK) (!PRESETn || $rose(PRESETn)) |-> !irq)
      else $error("irq high after reset");

  end
  else
  begin : g_phase

    //////////////////////////////
    // APB phases
    //////////////////////////////

    assert property (@(posedge PCLK) disable iff (!PRESETn) !(phase.setup && phase.access))
      else $error("setup and access high together");

  end

endmodule

// Wishbone port and irq live in the log
bind apb_violation_log apb_checker_asserts #(.CHECK_WB(1'b1)) log_chk (
  .PCLK(PCLK), .PRESETn(PRESETn), .wb_req(wb_req), .wb_rsp(wb_rsp), .irq(irq), .phase('0)
);
// Phases live in the tracker
bind apb_phase_tracker apb_checker_asserts #(.CHECK_WB(1'b0)) trk_chk (
  .PCLK(PCLK), .PRESETn(PRESETn), .wb_req('0), .wb_rsp('0), .irq(1'b0), .phase(phase)
);

// File: sim/apb_checker_tb.sv
// APB checker testbench
`timescale 1ns/1ps
`include "apb_checker_params.svh"

module apb_checker_tb;

  // Fault kinds for a table row
  localparam logic [2:0] F_NONE      = 3'd0;
  localparam logic [2:0] F_PSEL_DROP = 3'd1;
  localparam logic [2:0] F_EN_SETUP  = 3'd2;
  localparam logic [2:0] F_EN_ACCESS = 3'd3;
  localparam logic [2:0] F_HOLD      = 3'd4;
  localparam logic [2:0] F_NO_READY  = 3'd5;

  localparam int NROWS      = 21;
  localparam int MAX_CYCLES = NROWS * 40;

  // One scenario, field selects the signal changed by F_HOLD
  typedef struct packed {
    logic [`APB_ADDR_W-1:0] addr;
    logic                   write;
    logic [`APB_STRB_W-1:0] strb;
    logic [4:0]             waits;
    logic [2:0]             fault;
    logic [2:0]             field;
    logic [10:0]            mask;
    logic [10:0]            exp_status;
    logic [`LOG_CNT_W-1:0]  exp_count;
  } row_t;

  logic                      PCLK;
  logic                      PRESETn;
  apb_checker_pkg::apb_req_t req;
  apb_checker_pkg::apb_rsp_t rsp;
  apb_checker_pkg::wb_req_t  wb_req;
  apb_checker_pkg::wb_rsp_t  wb_rsp;
  logic                      irq;

  row_t        rows [NROWS];
  logic [15:0] lfsr_state;
  logic [31:0] rd;
  int          cycles;

  apb_checker_top dut0 (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .req     (req),
    .rsp     (rsp),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .irq     (irq)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per data bit
  task automatic random_word(output logic [31:0] w);
    for (int b = 0; b < 32; b++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      w[b] = lfsr_state[0];
    end
  endtask

  function automatic apb_checker_pkg::apb_req_t change_field(
    input apb_checker_pkg::apb_req_t q, input logic [2:0] field);
    apb_checker_pkg::apb_req_t r;
    r = q;
    case (field)
      3'd0:    r.paddr  = q.paddr ^ 32'h10;
      3'd1:    r.pwrite = ~q.pwrite;
      3'd2:    r.pstrb  = ~q.pstrb;
      3'd3:    r.pprot  = q.pprot ^ 3'b001;
      default: r.pwdata = ~q.pwdata;
    endcase
    return r;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
    $display("Finished with errors");
    $fatal(1, "Stopped at first error");
  endtask

  // Wishbone classic single access, waits for ack
  task automatic wb_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    wb_req = '{1'b1, 1'b1, we, adr, wdat};
    do
    begin
      @(posedge PCLK);
      #1;
    end
    while (!wb_rsp.ack);
    rdat   = wb_rsp.dat;
    wb_req = '0;
  endtask

  // Setup, access with wait states, then one idle cycle
  task automatic apb_transfer(input row_t r);
    apb_checker_pkg::apb_req_t q;
    logic [31:0]               wd;
    int                        waits;
    random_word(wd);
    q = '{1'b1, r.fault == F_EN_SETUP, r.addr, r.write, r.strb, 3'b010, wd};
    waits = (r.fault == F_NO_READY) ? `WD_LIMIT + 4 : int'(r.waits);
    req = q;
    rsp = '0;
    @(posedge PCLK);
    #1;
    // First access cycle carries the access-phase faults
    q.penable = (r.fault != F_EN_ACCESS);
    if (r.fault == F_HOLD)
      q = change_field(q, r.field);
    for (int i = 0; i <= waits; i++)
    begin
      if (r.fault == F_PSEL_DROP && i == 1)
        break;
      req = q;
      rsp.pready = (i == waits);
      @(posedge PCLK);
      #1;
      q.penable = 1'b1;
    end
    req = '0;
    rsp = '0;
    @(posedge PCLK);
    #1;
  endtask

  //////////////////////////////
  // Scenario table
  //////////////////////////////

  // Columns: addr, write, strb, waits, fault, field, mask, status, count
  task automatic fill_table;
    // Clean transfers, every valid strobe shape
    rows[0]  = '{32'h1000, 1'b1, 4'h1, 5'd0, F_NONE, 3'd0, 11'h000, 11'h000, 16'd0};
    rows[1]  = '{32'h1001, 1'b1, 4'h2, 5'd1, F_NONE, 3'd0, 11'h000, 11'h000, 16'd0};
    rows[2]  = '{32'h1002, 1'b1, 4'h4, 5'd2, F_NONE, 3'd0, 11'h000, 11'h000, 16'd0};
    rows[3]  = '{32'h1003, 1'b1, 4'h8, 5'd3, F_NONE, 3'd0, 11'h000, 11'h000, 16'd0};
    rows[4]  = '{32'h1004, 1'b1, 4'h3, 5'd0, F_NONE, 3'd0, 11'h000, 11'h000, 16'd0};
    rows[5]  = '{32'h1006, 1'b1, 4'hC, 5'd1, F_NONE, 3'd0, 11'h000, 11'h000, 16'd0};
    rows[6]  = '{32'h1008, 1'b1, 4'hF, 5'd2, F_NONE, 3'd0, 11'h000, 11'h000, 16'd0};
    rows[7]  = '{32'h100C, 1'b0, 4'h0, 5'd3, F_NONE, 3'd0, 11'h000, 11'h000, 16'd0};
    // Full mask with nothing flagged keeps irq low
    rows[8]  = '{32'h1010, 1'b0, 4'h0, 5'd0, F_NONE, 3'd0, 11'h7FF, 11'h000, 16'd0};
    // Phase rules, row 10 masks the flag off
    rows[9]  = '{32'h2000, 1'b1, 4'hF, 5'd1, F_EN_SETUP, 3'd0, 11'h002, 11'h002, 16'd1};
    rows[10] = '{32'h2004, 1'b1, 4'hF, 5'd1, F_EN_ACCESS, 3'd0, 11'h001, 11'h004, 16'd1};
    rows[11] = '{32'h2008, 1'b0, 4'h0, 5'd2, F_PSEL_DROP, 3'd0, 11'h001, 11'h001, 16'd1};
    // One field changed in a wait state
    rows[12] = '{32'h3000, 1'b1, 4'hF, 5'd1, F_HOLD, 3'd0, 11'h000, 11'h008, 16'd1};
    rows[13] = '{32'h3004, 1'b1, 4'hF, 5'd1, F_HOLD, 3'd1, 11'h000, 11'h010, 16'd1};
    rows[14] = '{32'h3008, 1'b1, 4'hF, 5'd2, F_HOLD, 3'd2, 11'h000, 11'h020, 16'd1};
    rows[15] = '{32'h300C, 1'b0, 4'h0, 5'd1, F_HOLD, 3'd3, 11'h000, 11'h040, 16'd1};
    rows[16] = '{32'h3010, 1'b1, 4'hF, 5'd3, F_HOLD, 3'd4, 11'h080, 11'h080, 16'd1};
    // Strobe shape and alignment
    rows[17] = '{32'h4000, 1'b1, 4'h5, 5'd0, F_NONE, 3'd0, 11'h000, 11'h100, 16'd1};
    rows[18] = '{32'h4001, 1'b1, 4'h4, 5'd0, F_NONE, 3'd0, 11'h000, 11'h200, 16'd1};
    rows[19] = '{32'h4002, 1'b0, 4'h0, 5'd1, F_NONE, 3'd0, 11'h200, 11'h200, 16'd1};
    // pready withheld past the watchdog limit
    rows[20] = '{32'h5000, 1'b1, 4'hF, 5'd0, F_NO_READY, 3'd0, 11'h400, 11'h400, 16'd1};
  endtask

  //////////////////////////////
  // Clock, reset and timeout
  //////////////////////////////

  initial
  begin
    PCLK = 1'b0;
    forever
      #5 PCLK = ~PCLK;
  end

  initial
  begin
    cycles = 0;
    forever
    begin
      @(posedge PCLK);
      cycles++;
      if (cycles > MAX_CYCLES)
      begin
        $display("Timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display("Finished with errors");
        $fatal(1, "Run did not complete");
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    PRESETn    = 1'b0;
    req        = '0;
    rsp        = '0;
    wb_req     = '0;
    lfsr_state = 16'd73;
    fill_table();
    repeat (2) @(posedge PCLK);
    #1;
    PRESETn = 1'b1;
    assert (irq == 1'b0) else report_mismatch("irq after reset", 32'(irq), 32'd0);
    for (int n = 0; n < NROWS; n++)
    begin
      wb_access(1'b1, `WB_ADR_W'(`REG_MASK), 32'(rows[n].mask), rd);
      wb_access(1'b0, `WB_ADR_W'(`REG_MASK), 32'd0, rd);
      assert (rd == 32'(rows[n].mask)) else report_mismatch("mask", rd, 32'(rows[n].mask));
      apb_transfer(rows[n]);
      // irq only for flags whose mask bit is set
      assert (irq == |(rows[n].exp_status & rows[n].mask))
        else report_mismatch("irq", 32'(irq), 32'(|(rows[n].exp_status & rows[n].mask)));
      wb_access(1'b0, `WB_ADR_W'(`REG_STATUS), 32'd0, rd);
      assert (rd == 32'(rows[n].exp_status))
        else report_mismatch("status", rd, 32'(rows[n].exp_status));
      wb_access(1'b0, `WB_ADR_W'(`REG_COUNT), 32'd0, rd);
      assert (rd == 32'(rows[n].exp_count))
        else report_mismatch("count", rd, 32'(rows[n].exp_count));
      // Write ones to status, any write to count
      wb_access(1'b1, `WB_ADR_W'(`REG_STATUS), 32'h7FF, rd);
      wb_access(1'b1, `WB_ADR_W'(`REG_COUNT), 32'd0, rd);
      wb_access(1'b0, `WB_ADR_W'(`REG_STATUS), 32'd0, rd);
      assert (rd == 32'd0) else report_mismatch("status after clear", rd, 32'd0);
      assert (irq == 1'b0) else report_mismatch("irq after clear", 32'(irq), 32'd0);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: apb_checker_top.f
+incdir+include
src/apb_checker_pkg.sv
src/apb_phase_tracker.sv
src/apb_hold_checker.sv
src/apb_strobe_checker.sv
src/apb_violation_log.sv
src/apb_checker_top.sv
sim/apb_checker_asserts.sv
sim/apb_checker_tb.sv
